// File: design/core_complex_pkg.sv
`default_nettype none

package core_complex_pkg;

  localparam int X_CORD_W    = 2;
  localparam int Y_CORD_W    = 2;
  localparam int TILE_ADDR_W = 4;
  localparam int MC_DATA_W   = 16;

  localparam int TILE_MEM_WORDS = 2 ** TILE_ADDR_W;

  localparam int FWD_PKT_W = 1 + Y_CORD_W + X_CORD_W + TILE_ADDR_W + MC_DATA_W;
  localparam int REV_PKT_W = MC_DATA_W + Y_CORD_W + X_CORD_W + TILE_ADDR_W;

  typedef logic [X_CORD_W-1:0]    x_cord_t;
  typedef logic [Y_CORD_W-1:0]    y_cord_t;
  typedef logic [TILE_ADDR_W-1:0] tile_addr_t;
  typedef logic [MC_DATA_W-1:0]   mc_data_t;

  // {op, dst_y, dst_x, addr, data}, op 1 is a store
  typedef logic [FWD_PKT_W-1:0] fwd_pkt_t;
  // {data, src_y, src_x, addr}
  typedef logic [REV_PKT_W-1:0] rev_pkt_t;

  localparam int FWD_DATA_LSB = 0;
  localparam int FWD_ADDR_LSB = FWD_DATA_LSB + MC_DATA_W;
  localparam int FWD_X_LSB    = FWD_ADDR_LSB + TILE_ADDR_W;
  localparam int FWD_Y_LSB    = FWD_X_LSB + X_CORD_W;
  localparam int FWD_OP_BIT   = FWD_Y_LSB + Y_CORD_W;

  localparam int REV_ADDR_LSB = 0;
  localparam int REV_X_LSB    = REV_ADDR_LSB + TILE_ADDR_W;
  localparam int REV_Y_LSB    = REV_X_LSB + X_CORD_W;
  localparam int REV_DATA_LSB = REV_Y_LSB + Y_CORD_W;

  // direction held in the tile forward output register
  typedef enum logic [1:0]
  {
    FWD_IDLE,
    FWD_EAST,
    FWD_SOUTH
  } tile_state_e;

endpackage

`default_nettype wire

// File: design/mc_link_rx.sv
`timescale 1ns/10ps
`default_nettype none

module mc_link_rx
  #(parameter int LINK_FIFO_DEPTH = 4
  )
  (input  logic                       mc_clk_i
  ,input  logic                       rst_n_i

  ,input  logic                       link_v_i
  ,input  core_complex_pkg::fwd_pkt_t link_data_i
  ,output logic                       link_token_o

  ,output logic                       pkt_v_o
  ,output core_complex_pkg::fwd_pkt_t pkt_o
  ,input  logic                       pkt_ready_i
  );

  import core_complex_pkg::*;

  localparam int PTR_W = (LINK_FIFO_DEPTH > 1) ? $clog2(LINK_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(LINK_FIFO_DEPTH + 1);

  fwd_pkt_t         mem_q [LINK_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             enq;
  logic             deq;

  assign full = (count_q == CNT_W'(LINK_FIFO_DEPTH));
  // sender out of credit, packet is lost
  assign enq  = link_v_i & !full;
  assign deq  = pkt_v_o & pkt_ready_i;

  assign pkt_v_o      = (count_q != '0);
  assign pkt_o        = mem_q[rd_ptr_q];
  // one credit back per dequeue
  assign link_token_o = deq;

  always_ff @(posedge mc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(LINK_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (deq)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(LINK_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + CNT_W'(enq) - CNT_W'(deq);
    end
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (enq)
      mem_q[wr_ptr_q] <= link_data_i;
  end

endmodule

`default_nettype wire

// File: design/mc_tile.sv
`timescale 1ns/10ps
`default_nettype none

module mc_tile
  #(parameter int TILE_X = 0
  ,parameter int TILE_Y = 0
  ,parameter bit LAST_X = 1'b0
  ,parameter bit LAST_Y = 1'b0
  )
  (input  logic                       mc_clk_i
  ,input  logic                       rst_n_i

  ,input  logic                       fwd_v_i
  ,input  core_complex_pkg::fwd_pkt_t fwd_i
  ,output logic                       fwd_ready_o

  ,output logic                       east_v_o
  ,output core_complex_pkg::fwd_pkt_t east_o
  ,input  logic                       east_ready_i

  ,output logic                       south_v_o
  ,output core_complex_pkg::fwd_pkt_t south_o
  ,input  logic                       south_ready_i

  ,input  logic                       rev_east_v_i
  ,input  core_complex_pkg::rev_pkt_t rev_east_i
  ,output logic                       rev_east_ready_o

  ,input  logic                       rev_south_v_i
  ,input  core_complex_pkg::rev_pkt_t rev_south_i
  ,output logic                       rev_south_ready_o

  ,output logic                       rev_v_o
  ,output core_complex_pkg::rev_pkt_t rev_o
  ,input  logic                       rev_ready_i
  );

  import core_complex_pkg::*;

  localparam x_cord_t MY_X = x_cord_t'(TILE_X);
  localparam y_cord_t MY_Y = y_cord_t'(TILE_Y);

  tile_state_e fwd_state_q;
  fwd_pkt_t    fwd_pkt_q;
  mc_data_t    mem_q [TILE_MEM_WORDS];
  logic        ret_v_q;
  rev_pkt_t    ret_pkt_q;
  logic        rev_v_q;
  rev_pkt_t    rev_pkt_q;
  rev_pkt_t    rev_next;

  x_cord_t     dst_x;
  y_cord_t     dst_y;
  tile_addr_t  dst_addr;
  mc_data_t    dst_data;
  logic        is_store;
  logic        miss_x;
  logic        miss_y;
  logic        pass_south;
  logic        pass_east;
  logic        hit;
  logic        out_free;
  logic        fwd_take;
  logic        ld_take;
  logic        ret_take;
  logic        rev_out_free;

  assign is_store = fwd_i[FWD_OP_BIT];
  assign dst_y    = fwd_i[FWD_Y_LSB +: Y_CORD_W];
  assign dst_x    = fwd_i[FWD_X_LSB +: X_CORD_W];
  assign dst_addr = fwd_i[FWD_ADDR_LSB +: TILE_ADDR_W];
  assign dst_data = fwd_i[FWD_DATA_LSB +: MC_DATA_W];

  // y first, then x; edge tiles have no exit and drop
  assign miss_y     = (dst_y != MY_Y);
  assign miss_x     = (dst_x != MY_X);
  assign pass_south = miss_y & !LAST_Y;
  assign pass_east  = !miss_y & miss_x & !LAST_X;
  assign hit        = !miss_y & !miss_x;

  assign east_v_o  = (fwd_state_q == FWD_EAST);
  assign south_v_o = (fwd_state_q == FWD_SOUTH);
  assign east_o    = fwd_pkt_q;
  assign south_o   = fwd_pkt_q;
  assign out_free  = (fwd_state_q == FWD_IDLE) | (east_v_o & east_ready_i)
                   | (south_v_o & south_ready_i);

  always_comb
  begin
    if (pass_south | pass_east)
      fwd_ready_o = out_free;
    else if (hit & !is_store)
      fwd_ready_o = !ret_v_q;
    else
      fwd_ready_o = 1'b1;
  end

  assign fwd_take = fwd_v_i & fwd_ready_o;
  assign ld_take  = fwd_take & hit & !is_store;

  always_ff @(posedge mc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      fwd_state_q <= FWD_IDLE;
    else if (out_free)
    begin
      if (fwd_v_i & pass_south)
        fwd_state_q <= FWD_SOUTH;
      else if (fwd_v_i & pass_east)
        fwd_state_q <= FWD_EAST;
      else
        fwd_state_q <= FWD_IDLE;
    end
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (out_free & fwd_v_i & (pass_south | pass_east))
      fwd_pkt_q <= fwd_i;
  end

  always_ff @(posedge mc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < TILE_MEM_WORDS; i++)
        mem_q[i] <= '0;
    end
    else if (fwd_take & hit & is_store)
      mem_q[dst_addr] <= dst_data;
  end

  // local return loses to both neighbors
  assign ret_take = ret_v_q & rev_out_free & !rev_south_v_i & !rev_east_v_i;

  always_ff @(posedge mc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ret_v_q <= 1'b0;
    else if (ld_take)
      ret_v_q <= 1'b1;
    else if (ret_take)
      ret_v_q <= 1'b0;
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (ld_take)
    begin
      ret_pkt_q[REV_DATA_LSB +: MC_DATA_W]   <= mem_q[dst_addr];
      ret_pkt_q[REV_Y_LSB +: Y_CORD_W]       <= MY_Y;
      ret_pkt_q[REV_X_LSB +: X_CORD_W]       <= MY_X;
      ret_pkt_q[REV_ADDR_LSB +: TILE_ADDR_W] <= dst_addr;
    end
  end

  // reverse merge, south then east then local
  assign rev_out_free      = !rev_v_q | rev_ready_i;
  assign rev_south_ready_o = rev_out_free;
  assign rev_east_ready_o  = rev_out_free & !rev_south_v_i;

  always_comb
  begin
    if (rev_south_v_i)
      rev_next = rev_south_i;
    else if (rev_east_v_i)
      rev_next = rev_east_i;
    else
      rev_next = ret_pkt_q;
  end

  always_ff @(posedge mc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rev_v_q <= 1'b0;
    else if (rev_out_free)
      rev_v_q <= rev_south_v_i | rev_east_v_i | ret_v_q;
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (rev_out_free)
      rev_pkt_q <= rev_next;
  end

  assign rev_v_o = rev_v_q;
  assign rev_o   = rev_pkt_q;

endmodule

`default_nettype wire

// File: design/mc_pod_row.sv
`timescale 1ns/10ps
`default_nettype none

module mc_pod_row
  #(parameter int NUM_TILES_X = 2
  ,parameter int ROW_Y = 0
  ,parameter bit LAST_Y = 1'b0
  )
  (input  logic                                         mc_clk_i
  ,input  logic                                         rst_n_i

  ,input  logic                                         fwd_v_i
  ,input  core_complex_pkg::fwd_pkt_t                   fwd_i
  ,output logic                                         fwd_ready_o

  ,output logic [NUM_TILES_X-1:0]                       south_v_o
  ,output core_complex_pkg::fwd_pkt_t [NUM_TILES_X-1:0] south_o
  ,input  logic [NUM_TILES_X-1:0]                       south_ready_i

  ,input  logic                                         rev_south_v_i
  ,input  core_complex_pkg::rev_pkt_t                   rev_south_i
  ,output logic                                         rev_south_ready_o

  ,output logic                                         rev_v_o
  ,output core_complex_pkg::rev_pkt_t                   rev_o
  ,input  logic                                         rev_ready_i
  );

  import core_complex_pkg::*;

  // index x is the west side of tile x
  logic [NUM_TILES_X:0]   fwd_v;
  logic [NUM_TILES_X:0]   fwd_ready;
  fwd_pkt_t               fwd_pkt [NUM_TILES_X+1];
  logic [NUM_TILES_X:0]   rev_v;
  logic [NUM_TILES_X:0]   rev_ready;
  rev_pkt_t               rev_pkt [NUM_TILES_X+1];
  logic [NUM_TILES_X-1:0] rs_v;
  logic [NUM_TILES_X-1:0] rs_ready;
  rev_pkt_t               rs_pkt [NUM_TILES_X];

  assign fwd_v[0]    = fwd_v_i;
  assign fwd_pkt[0]  = fwd_i;
  assign fwd_ready_o = fwd_ready[0];

  assign rev_v_o      = rev_v[0];
  assign rev_o        = rev_pkt[0];
  assign rev_ready[0] = rev_ready_i;

  // east edge
  assign fwd_ready[NUM_TILES_X] = 1'b1;
  assign rev_v[NUM_TILES_X]     = 1'b0;
  assign rev_pkt[NUM_TILES_X]   = '0;

  assign rev_south_ready_o = rs_ready[0];

  for (genvar x = 0; x < NUM_TILES_X; x++)
  begin: tile
    // only column 0 sees the row below
    if (x == 0)
    begin: rs_link
      assign rs_v[x]   = rev_south_v_i;
      assign rs_pkt[x] = rev_south_i;
    end
    else
    begin: rs_tie
      assign rs_v[x]   = 1'b0;
      assign rs_pkt[x] = '0;
    end

    mc_tile
      #(.TILE_X (x)
      ,.TILE_Y  (ROW_Y)
      ,.LAST_X  (x == NUM_TILES_X - 1)
      ,.LAST_Y  (LAST_Y)
      )
      u_tile
      (.mc_clk_i          (mc_clk_i)
      ,.rst_n_i           (rst_n_i)
      ,.fwd_v_i           (fwd_v[x])
      ,.fwd_i             (fwd_pkt[x])
      ,.fwd_ready_o       (fwd_ready[x])
      ,.east_v_o          (fwd_v[x+1])
      ,.east_o            (fwd_pkt[x+1])
      ,.east_ready_i      (fwd_ready[x+1])
      ,.south_v_o         (south_v_o[x])
      ,.south_o           (south_o[x])
      ,.south_ready_i     (south_ready_i[x])
      ,.rev_east_v_i      (rev_v[x+1])
      ,.rev_east_i        (rev_pkt[x+1])
      ,.rev_east_ready_o  (rev_ready[x+1])
      ,.rev_south_v_i     (rs_v[x])
      ,.rev_south_i       (rs_pkt[x])
      ,.rev_south_ready_o (rs_ready[x])
      ,.rev_v_o           (rev_v[x])
      ,.rev_o             (rev_pkt[x])
      ,.rev_ready_i       (rev_ready[x])
      );
  end

endmodule

`default_nettype wire

// File: design/mc_link_tx.sv
`timescale 1ns/10ps
`default_nettype none

module mc_link_tx
  #(parameter int LINK_FIFO_DEPTH = 4
  )
  (input  logic                       mc_clk_i
  ,input  logic                       rst_n_i

  ,input  logic                       pkt_v_i
  ,input  core_complex_pkg::rev_pkt_t pkt_i
  ,output logic                       pkt_ready_o

  ,output logic                       link_v_o
  ,output core_complex_pkg::rev_pkt_t link_data_o
  ,input  logic                       link_token_i
  );

  localparam int CNT_W = $clog2(LINK_FIFO_DEPTH + 1);

  logic [CNT_W-1:0] credit_q;
  logic             send;

  // stall the reverse chain once the receiver is full
  assign pkt_ready_o = (credit_q != '0);
  assign send        = pkt_v_i & pkt_ready_o;

  always_ff @(posedge mc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      credit_q <= CNT_W'(LINK_FIFO_DEPTH);
      link_v_o <= 1'b0;
    end
    else
    begin
      link_v_o <= send;
      credit_q <= credit_q - CNT_W'(send) + CNT_W'(link_token_i);
    end
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (send)
      link_data_o <= pkt_i;
  end

endmodule

`default_nettype wire

// File: design/core_complex.sv
`timescale 1ns/10ps
`default_nettype none

module core_complex
  #(parameter int NUM_TILES_X = 2
  ,parameter int NUM_PODS_Y = 2
  ,parameter int LINK_FIFO_DEPTH = 4
  )
  (input  logic                       mc_clk_i
  ,input  logic                       rst_n_i

  ,input  logic                       mc_fwd_link_v_i
  ,input  core_complex_pkg::fwd_pkt_t mc_fwd_link_data_i
  ,output logic                       mc_fwd_link_token_o

  ,output logic                       mc_rev_link_v_o
  ,output core_complex_pkg::rev_pkt_t mc_rev_link_data_o
  ,input  logic                       mc_rev_link_token_i
  );

  import core_complex_pkg::*;

  logic [NUM_PODS_Y-1:0]                  row_fwd_v;
  logic [NUM_PODS_Y-1:0]                  row_fwd_ready;
  fwd_pkt_t                               row_fwd [NUM_PODS_Y];
  logic [NUM_PODS_Y-1:0][NUM_TILES_X-1:0] south_v;
  logic [NUM_PODS_Y-1:0][NUM_TILES_X-1:0] south_ready;
  fwd_pkt_t [NUM_TILES_X-1:0]             south_pkt [NUM_PODS_Y];
  // index y is the north reverse output of row y
  logic [NUM_PODS_Y:0]                    row_rev_v;
  logic [NUM_PODS_Y:0]                    row_rev_ready;
  rev_pkt_t                               row_rev [NUM_PODS_Y+1];

  mc_link_rx
    #(.LINK_FIFO_DEPTH (LINK_FIFO_DEPTH))
    u_link_rx
    (.mc_clk_i     (mc_clk_i)
    ,.rst_n_i      (rst_n_i)
    ,.link_v_i     (mc_fwd_link_v_i)
    ,.link_data_i  (mc_fwd_link_data_i)
    ,.link_token_o (mc_fwd_link_token_o)
    ,.pkt_v_o      (row_fwd_v[0])
    ,.pkt_o        (row_fwd[0])
    ,.pkt_ready_i  (row_fwd_ready[0])
    );

  // nothing returns from below the last row
  assign row_rev_v[NUM_PODS_Y] = 1'b0;
  assign row_rev[NUM_PODS_Y]   = '0;

  for (genvar y = 0; y < NUM_PODS_Y; y++)
  begin: pod
    mc_pod_row
      #(.NUM_TILES_X (NUM_TILES_X)
      ,.ROW_Y        (y)
      ,.LAST_Y       (y == NUM_PODS_Y - 1)
      )
      u_pod_row
      (.mc_clk_i          (mc_clk_i)
      ,.rst_n_i           (rst_n_i)
      ,.fwd_v_i           (row_fwd_v[y])
      ,.fwd_i             (row_fwd[y])
      ,.fwd_ready_o       (row_fwd_ready[y])
      ,.south_v_o         (south_v[y])
      ,.south_o           (south_pkt[y])
      ,.south_ready_i     (south_ready[y])
      ,.rev_south_v_i     (row_rev_v[y+1])
      ,.rev_south_i       (row_rev[y+1])
      ,.rev_south_ready_o (row_rev_ready[y+1])
      ,.rev_v_o           (row_rev_v[y])
      ,.rev_o             (row_rev[y])
      ,.rev_ready_i       (row_rev_ready[y])
      );

    // y-first routing only ever leaves a row through column 0
    for (genvar x = 0; x < NUM_TILES_X; x++)
    begin: south
      if ((x == 0) && (y < NUM_PODS_Y - 1))
      begin: stitch
        assign row_fwd_v[y+1]  = south_v[y][x];
        assign row_fwd[y+1]    = south_pkt[y][x];
        assign south_ready[y][x] = row_fwd_ready[y+1];
      end
      else
      begin: tie
        assign south_ready[y][x] = 1'b1;
      end
    end
  end

  mc_link_tx
    #(.LINK_FIFO_DEPTH (LINK_FIFO_DEPTH))
    u_link_tx
    (.mc_clk_i     (mc_clk_i)
    ,.rst_n_i      (rst_n_i)
    ,.pkt_v_i      (row_rev_v[0])
    ,.pkt_i        (row_rev[0])
    ,.pkt_ready_o  (row_rev_ready[0])
    ,.link_v_o     (mc_rev_link_v_o)
    ,.link_data_o  (mc_rev_link_data_o)
    ,.link_token_i (mc_rev_link_token_i)
    );

endmodule

`default_nettype wire

// File: tests/core_complex_props.sv
`timescale 1ns/10ps
`default_nettype none

module core_complex_props
  #(parameter int LINK_FIFO_DEPTH = 4
  )
  (input logic mc_clk_i
  ,input logic rst_n_i
  ,input logic mc_fwd_link_v_i
  ,input logic mc_fwd_link_token_o
  ,input logic mc_rev_link_v_o
  ,input logic mc_rev_link_token_i
  );

  // reverse sends not yet paid back by a token
  int rev_used_q;
  // forward packets held inside the receiver
  int fwd_held_q;
  // latched high by any failing property
  bit prop_failed = 1'b0;

  always_ff @(posedge mc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rev_used_q <= 0;
      fwd_held_q <= 0;
    end
    else
    begin
      rev_used_q <= rev_used_q + int'(mc_rev_link_v_o) - int'(mc_rev_link_token_i);
      fwd_held_q <= fwd_held_q + int'(mc_fwd_link_v_i) - int'(mc_fwd_link_token_o);
    end
  end

  a_reset_quiet: assert property (@(posedge mc_clk_i)
    !rst_n_i |-> (!mc_rev_link_v_o && !mc_fwd_link_token_o))
    else
    begin
      prop_failed = 1'b1;
      $error("link valid or token high during reset");
    end

  a_rev_credit: assert property (@(posedge mc_clk_i) disable iff (!rst_n_i)
    mc_rev_link_v_o |-> (rev_used_q < LINK_FIFO_DEPTH))
    else
    begin
      prop_failed = 1'b1;
      $error("reverse link valid with no credit left");
    end

  a_fwd_token: assert property (@(posedge mc_clk_i) disable iff (!rst_n_i)
    mc_fwd_link_token_o |-> (fwd_held_q > 0))
    else
    begin
      prop_failed = 1'b1;
      $error("forward token with no packet held");
    end

endmodule

bind core_complex core_complex_props
  #(.LINK_FIFO_DEPTH (LINK_FIFO_DEPTH))
  u_props
  (.mc_clk_i            (mc_clk_i)
  ,.rst_n_i             (rst_n_i)
  ,.mc_fwd_link_v_i     (mc_fwd_link_v_i)
  ,.mc_fwd_link_token_o (mc_fwd_link_token_o)
  ,.mc_rev_link_v_o     (mc_rev_link_v_o)
  ,.mc_rev_link_token_i (mc_rev_link_token_i)
  );

`default_nettype wire

// File: tests/tb_core_complex.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core_complex;

  import core_complex_pkg::*;

  localparam int NUM_TILES_X     = 2;
  localparam int NUM_PODS_Y      = 2;
  localparam int LINK_FIFO_DEPTH = 4;
  localparam int NUM_TILES       = NUM_TILES_X * NUM_PODS_Y;
  localparam int N_BURST         = 12;
  localparam int N_HOLD          = 24;
  localparam int N_OOR           = 6;
  localparam int NUM_PKTS        = 2 * NUM_TILES + 2 * NUM_TILES * TILE_MEM_WORDS
                                 + N_BURST + N_HOLD + N_OOR;
  localparam int TIMEOUT_CYCLES  = NUM_PKTS * 40 + 500;

  logic     mc_clk_i;
  logic     rst_n_i;
  logic     mc_fwd_link_v_i;
  fwd_pkt_t mc_fwd_link_data_i;
  logic     mc_fwd_link_token_o;
  logic     mc_rev_link_v_o;
  rev_pkt_t mc_rev_link_data_o;
  logic     mc_rev_link_token_i;

  logic [15:0] stim_lfsr;
  logic [15:0] sink_lfsr;
  fwd_pkt_t    fwd_q [$];
  rev_pkt_t    exp_q [NUM_TILES][$];
  mc_data_t    mem_model [NUM_TILES][TILE_MEM_WORDS];
  int          fwd_credits;
  int          tok_pending;
  int          tok_wait;
  bit          tok_hold;
  int          hold_rcvd;
  int          cycle_cnt = 0;
  string       test_name;

  core_complex
    #(.NUM_TILES_X     (NUM_TILES_X)
    ,.NUM_PODS_Y      (NUM_PODS_Y)
    ,.LINK_FIFO_DEPTH (LINK_FIFO_DEPTH)
    )
    u_dut
    (.mc_clk_i            (mc_clk_i)
    ,.rst_n_i             (rst_n_i)
    ,.mc_fwd_link_v_i     (mc_fwd_link_v_i)
    ,.mc_fwd_link_data_i  (mc_fwd_link_data_i)
    ,.mc_fwd_link_token_o (mc_fwd_link_token_o)
    ,.mc_rev_link_v_o     (mc_rev_link_v_o)
    ,.mc_rev_link_data_o  (mc_rev_link_data_o)
    ,.mc_rev_link_token_i (mc_rev_link_token_i)
    );

  initial
  begin
    mc_clk_i = 1'b0;
    forever #4 mc_clk_i = ~mc_clk_i;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [15:0] draw(inout logic [15:0] state, input int nbits);
    logic [15:0] val;
    int          i;
    val = '0;
    for (i = 0; i < nbits; i++)
    begin
      state = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
      val   = {val[14:0], state[0]};
    end
    return val;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "run stopped at first failure");
  endtask

  function automatic int expected_left();
    int n;
    int t;
    n = 0;
    for (t = 0; t < NUM_TILES; t++)
      n += exp_q[t].size();
    return n;
  endfunction

  task automatic send_store(input int x, input int y, input int a, input mc_data_t d);
    fwd_q.push_back({1'b1, y_cord_t'(y), x_cord_t'(x), tile_addr_t'(a), d});
    // out of range stores are dropped by the grid
    if (x < NUM_TILES_X && y < NUM_PODS_Y)
      mem_model[y * NUM_TILES_X + x][a] = d;
  endtask

  task automatic send_load(input int x, input int y, input int a);
    int t;
    t = y * NUM_TILES_X + x;
    fwd_q.push_back({1'b0, y_cord_t'(y), x_cord_t'(x), tile_addr_t'(a), mc_data_t'(0)});
    if (x < NUM_TILES_X && y < NUM_PODS_Y)
      exp_q[t].push_back({mem_model[t][a], y_cord_t'(y), x_cord_t'(x), tile_addr_t'(a)});
  endtask

  task automatic check_return(input rev_pkt_t got);
    int       x;
    int       y;
    int       t;
    rev_pkt_t want;
    x = int'(got[REV_X_LSB +: X_CORD_W]);
    y = int'(got[REV_Y_LSB +: Y_CORD_W]);
    t = y * NUM_TILES_X + x;
    assert (x < NUM_TILES_X && y < NUM_PODS_Y && exp_q[t].size() > 0)
    else
      abort_run($sformatf("%s: return from tile x=%0d y=%0d that no load asked for",
                          test_name, x, y));
    want = exp_q[t].pop_front();
    assert (got == want)
    else
      abort_run($sformatf("ERR %s expected %h actual %h", test_name, want, got));
  endtask

  task automatic wait_drained();
    while (fwd_q.size() != 0 || fwd_credits != LINK_FIFO_DEPTH
           || expected_left() != 0 || tok_pending != 0)
      @(negedge mc_clk_i);
  endtask

  // forward link driver with its own credit count
  always @(negedge mc_clk_i)
  begin
    if (rst_n_i)
    begin
      if (fwd_q.size() > 0 && fwd_credits > 0)
      begin
        mc_fwd_link_data_i = fwd_q.pop_front();
        mc_fwd_link_v_i    = 1'b1;
        fwd_credits--;
      end
      else
        mc_fwd_link_v_i = 1'b0;
      // slot frees at the coming edge, usable from the next cycle
      if (mc_fwd_link_token_o)
        fwd_credits++;
      assert (fwd_credits <= LINK_FIFO_DEPTH)
      else
        abort_run("forward link returned more tokens than packets were sent");
    end
  end

  // reverse link sink, one token per packet after 0 to 7 cycles
  always @(negedge mc_clk_i)
  begin
    if (rst_n_i)
    begin
      if (mc_rev_link_v_o)
      begin
        check_return(mc_rev_link_data_o);
        tok_pending++;
        if (tok_hold)
          hold_rcvd++;
        assert (tok_pending <= LINK_FIFO_DEPTH)
        else
          abort_run("reverse link sent a packet without a credit");
      end
      mc_rev_link_token_i = 1'b0;
      if (!tok_hold && tok_pending > 0)
      begin
        if (tok_wait < 0)
          tok_wait = int'(draw(sink_lfsr, 3));
        if (tok_wait == 0)
        begin
          mc_rev_link_token_i = 1'b1;
          tok_pending--;
          tok_wait = -1;
        end
        else
          tok_wait--;
      end
    end
  end

  always @(posedge mc_clk_i)
  begin
    cycle_cnt++;
    if (u_dut.u_props.prop_failed)
      abort_run("a bound link property of the DUT failed");
    else if (cycle_cnt > TIMEOUT_CYCLES)
      abort_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  initial
  begin
    int x;
    int y;
    int a;
    int i;
    int t;
    mc_fwd_link_v_i     = 1'b0;
    mc_fwd_link_data_i  = '0;
    mc_rev_link_token_i = 1'b0;
    rst_n_i             = 1'b0;
    stim_lfsr           = 16'd12989;
    sink_lfsr           = 16'd12989;
    fwd_credits         = LINK_FIFO_DEPTH;
    tok_pending         = 0;
    tok_wait            = -1;
    tok_hold            = 1'b0;
    hold_rcvd           = 0;
    test_name           = "reset";
    for (t = 0; t < NUM_TILES; t++)
      for (a = 0; a < TILE_MEM_WORDS; a++)
        mem_model[t][a] = '0;
    repeat (2) @(posedge mc_clk_i);
    @(negedge mc_clk_i);
    rst_n_i = 1'b1;

    repeat (4)
    begin
      @(negedge mc_clk_i);
      assert (!mc_rev_link_v_o && !mc_fwd_link_token_o)
      else
        abort_run("link outputs became active before any packet was sent");
    end

    test_name = "unwritten";
    for (t = 0; t < NUM_TILES; t++)
      send_load(t % NUM_TILES_X, t / NUM_TILES_X, int'(draw(stim_lfsr, 4)));
    wait_drained();

    test_name = "store_load";
    for (y = 0; y < NUM_PODS_Y; y++)
      for (x = 0; x < NUM_TILES_X; x++)
        for (a = 0; a < TILE_MEM_WORDS; a++)
          send_store(x, y, a, draw(stim_lfsr, 16));
    for (y = 0; y < NUM_PODS_Y; y++)
      for (x = 0; x < NUM_TILES_X; x++)
        for (a = 0; a < TILE_MEM_WORDS; a++)
          send_load(x, y, a);
    wait_drained();

    test_name = "ordering";
    for (i = 0; i < N_BURST; i++)
      send_load(NUM_TILES_X - 1, NUM_PODS_Y - 1, int'(draw(stim_lfsr, 4)));
    wait_drained();

    // hold tokens until tx and the forward link both run dry
    test_name = "backpressure";
    hold_rcvd = 0;
    tok_hold  = 1'b1;
    for (i = 0; i < N_HOLD; i++)
    begin
      t = int'(draw(stim_lfsr, 8)) % NUM_TILES;
      send_load(t % NUM_TILES_X, t / NUM_TILES_X, int'(draw(stim_lfsr, 4)));
    end
    while (!(hold_rcvd >= LINK_FIFO_DEPTH && fwd_credits == 0))
      @(negedge mc_clk_i);
    tok_hold = 1'b0;
    wait_drained();

    test_name = "out_of_range";
    for (i = 0; i < N_OOR; i++)
    begin
      a = int'(draw(stim_lfsr, 4));
      if (i % 2 == 0)
        send_load(NUM_TILES_X + (i / 2) % 2, i % NUM_PODS_Y, a);
      else
        send_store(i % NUM_TILES_X, NUM_PODS_Y + (i / 2) % 2, a, draw(stim_lfsr, 16));
    end
    for (t = 0; t < NUM_TILES; t++)
      send_load(t % NUM_TILES_X, t / NUM_TILES_X, int'(draw(stim_lfsr, 4)));
    wait_drained();

    // quiet window so a stray return still gets caught
    test_name = "idle";
    repeat (40) @(negedge mc_clk_i);
    if (u_dut.u_props.prop_failed)
      abort_run("a bound link property of the DUT failed");
    else
    begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
design/core_complex_pkg.sv
design/mc_link_rx.sv
design/mc_tile.sv
design/mc_pod_row.sv
design/mc_link_tx.sv
design/core_complex.sv
tests/core_complex_props.sv
tests/tb_core_complex.sv

// File: Bender.yml
package:
  name: core_complex

sources:
  - design/core_complex_pkg.sv
  - design/mc_link_rx.sv
  - design/mc_tile.sv
  - design/mc_pod_row.sv
  - design/mc_link_tx.sv
  - design/core_complex.sv
  - target: test
    files:
      - tests/core_complex_props.sv
      - tests/tb_core_complex.sv
